// ==== hdl/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011, // decoded as unknown here
        op_store = 7'b0100011, // decoded as unknown here
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    // also used as the compare op
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000, // add or sub
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // srl or sra
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // sra and sub sit on the slt/sltu codes, picked by funct7[5]
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_b_imm,
        alumux2_s_imm, alumux2_j_imm, alumux2_rs2_out
    } alumux2_sel_t;

    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;

    typedef enum logic [1:0] {
        regfilemux_alu_out, regfilemux_br_en, regfilemux_u_imm, regfilemux_pc_plus4
    } regfilemux_sel_t;

    typedef enum logic [1:0] {
        pcmux_pc_plus4, // sequential
        pcmux_alu_out,  // branch target, only if br_en
        pcmux_alu_jump, // jal
        pcmux_alu_mod2  // jalr, bit 0 cleared
    } pcmux_sel_t;

endpackage : rv32i_pkg

`default_nettype wire

// ==== hdl/control_rom.sv ====
`default_nettype none

module control_rom
    import rv32i_pkg::*;
(
    input  rv32i_opcode     opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    output logic            load_regfile,
    output pcmux_sel_t      pcmux_sel,
    output alumux1_sel_t    alumux1_sel,
    output alumux2_sel_t    alumux2_sel,
    output cmpmux_sel_t     cmpmux_sel,
    output regfilemux_sel_t regfilemux_sel,
    output alu_ops          aluop,
    output branch_funct3_t  cmpop
);

    arith_funct3_t  arith_funct3;
    branch_funct3_t branch_funct3;

    assign arith_funct3  = arith_funct3_t'(funct3);
    assign branch_funct3 = branch_funct3_t'(funct3);

    always_comb begin
        load_regfile   = 1'b0; // unknown opcodes fall through as nops
        pcmux_sel      = pcmux_pc_plus4;
        alumux1_sel    = alumux1_rs1_out;
        alumux2_sel    = alumux2_i_imm;
        cmpmux_sel     = cmpmux_rs2_out;
        regfilemux_sel = regfilemux_alu_out;
        aluop          = alu_add;
        cmpop          = beq;

        case (opcode)
            op_lui: begin
                load_regfile   = 1'b1;
                regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc: begin
                alumux1_sel  = alumux1_pc_out;
                alumux2_sel  = alumux2_u_imm;
                load_regfile = 1'b1;
            end
            op_jal: begin
                alumux1_sel    = alumux1_pc_out;
                alumux2_sel    = alumux2_j_imm;
                pcmux_sel      = pcmux_alu_jump;
                load_regfile   = 1'b1;
                regfilemux_sel = regfilemux_pc_plus4; // link
            end
            op_jalr: begin
                alumux2_sel    = alumux2_i_imm;
                pcmux_sel      = pcmux_alu_mod2;
                load_regfile   = 1'b1;
                regfilemux_sel = regfilemux_pc_plus4;
            end
            op_br: begin
                alumux1_sel = alumux1_pc_out;
                alumux2_sel = alumux2_b_imm;
                pcmux_sel   = pcmux_alu_out; // taken only on br_en
                cmpop       = branch_funct3;
            end
            op_imm: begin
                load_regfile = 1'b1;
                case (arith_funct3)
                    sll: aluop = alu_sll; // funct7 not looked at
                    sr:  aluop = funct7[5] ? alu_sra : alu_srl;
                    slt: begin
                        cmpmux_sel     = cmpmux_i_imm;
                        cmpop          = blt;
                        regfilemux_sel = regfilemux_br_en;
                    end
                    sltu: begin
                        cmpmux_sel     = cmpmux_i_imm;
                        cmpop          = bltu;
                        regfilemux_sel = regfilemux_br_en;
                    end
                    default: aluop = alu_ops'(funct3); // no subi
                endcase
            end
            op_reg: begin
                alumux2_sel  = alumux2_rs2_out;
                load_regfile = 1'b1;
                case (arith_funct3)
                    add: aluop = funct7[5] ? alu_sub : alu_add;
                    sr:  aluop = funct7[5] ? alu_sra : alu_srl;
                    slt: begin
                        cmpop          = blt;
                        regfilemux_sel = regfilemux_br_en;
                    end
                    sltu: begin
                        cmpop          = bltu;
                        regfilemux_sel = regfilemux_br_en;
                    end
                    default: aluop = alu_ops'(funct3);
                endcase
            end
            default: ;
        endcase
    end

endmodule : control_rom

`default_nettype wire

// ==== hdl/regfile.sv ====
`default_nettype none

module regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        load,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] rd_data,
    output logic [31:0] rs1_out,
    output logic [31:0] rs2_out
);

    logic [31:0] regs [1:31]; // no storage for x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_out = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_out = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule : regfile

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`default_nettype none

module imm_gen (
    input  logic [31:0] instr,
    output logic [31:0] i_imm,
    output logic [31:0] s_imm,
    output logic [31:0] b_imm,
    output logic [31:0] u_imm,
    output logic [31:0] j_imm
);

    logic sign;

    assign sign = instr[31];

    assign i_imm = {{21{sign}}, instr[30:20]};
    assign s_imm = {{21{sign}}, instr[30:25], instr[11:7]};

    // branch offset is in halfwords
    assign b_imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    assign u_imm = {instr[31:12], 12'h000};

    assign j_imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule : imm_gen

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu
    import rv32i_pkg::*;
(
    input  alu_ops      aluop,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] f
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // upper bits ignored

    always_comb begin
        case (aluop)
            alu_add: f = a + b;
            alu_sll: f = a << shamt;
            alu_sra: f = unsigned'($signed(a) >>> shamt);
            alu_sub: f = a - b;
            alu_xor: f = a ^ b;
            alu_srl: f = a >> shamt;
            alu_or:  f = a | b;
            alu_and: f = a & b;
            default: f = a + b;
        endcase
    end

endmodule : alu

`default_nettype wire

// ==== hdl/cmp.sv ====
`default_nettype none

module cmp
    import rv32i_pkg::*;
(
    input  branch_funct3_t cmpop,
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    output logic           br_en
);

    always_comb begin
        case (cmpop)
            beq:     br_en = (a == b);
            bne:     br_en = (a != b);
            blt:     br_en = ($signed(a) < $signed(b));
            bge:     br_en = ($signed(a) >= $signed(b));
            bltu:    br_en = (a < b);
            bgeu:    br_en = (a >= b);
            default: br_en = 1'b0; // funct3 010/011 never branch
        endcase
    end

endmodule : cmp

`default_nettype wire

// ==== hdl/pc_unit.sv ====
`default_nettype none

module pc_unit
    import rv32i_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        advance,
    input  pcmux_sel_t  pcmux_sel,
    input  logic        br_en,
    input  logic [31:0] alu_out,
    output logic [31:0] pc,
    output logic [31:0] pc_plus4
);

    logic [31:0] pc_next;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (pcmux_sel)
            pcmux_alu_out:  pc_next = br_en ? alu_out : pc_plus4;
            pcmux_alu_jump: pc_next = alu_out;
            pcmux_alu_mod2: pc_next = {alu_out[31:1], 1'b0};
            default:        pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (advance) begin
            pc <= pc_next; // holds on idle cycles
        end
    end

endmodule : pc_unit

`default_nettype wire

// ==== hdl/writeback.sv ====
`default_nettype none

module writeback
    import rv32i_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            instr_valid,
    input  logic            load_regfile,
    input  regfilemux_sel_t regfilemux_sel,
    input  logic [4:0]      rd,
    input  logic [31:0]     alu_out,
    input  logic [31:0]     u_imm,
    input  logic [31:0]     pc_plus4,
    input  logic            br_en,
    output logic            load,
    output logic [31:0]     rd_data,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [31:0]     wb_data
);

    always_comb begin
        case (regfilemux_sel)
            regfilemux_br_en:    rd_data = {31'd0, br_en}; // slt result
            regfilemux_u_imm:    rd_data = u_imm;
            regfilemux_pc_plus4: rd_data = pc_plus4;
            default:             rd_data = alu_out;
        endcase
    end

    assign load = instr_valid & load_regfile;

    // report only writes that change architectural state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= load && (rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wb_rd   <= rd;
            wb_data <= rd_data;
        end
    end

endmodule : writeback

`default_nettype wire

// ==== hdl/rv32i_exec_top.sv ====
`default_nettype none

module rv32i_exec_top
    import rv32i_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    logic            load_regfile;
    pcmux_sel_t      pcmux_sel;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    cmpmux_sel_t     cmpmux_sel;
    regfilemux_sel_t regfilemux_sel;
    alu_ops          aluop;
    branch_funct3_t  cmpop;

    logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [31:0] rs1_out, rs2_out;
    logic [31:0] alu_a, alu_b, cmp_b;
    logic [31:0] alu_out, pc_plus4, rd_data;
    logic        br_en, load;

    // operand muxes
    assign alu_a = (alumux1_sel == alumux1_pc_out) ? pc : rs1_out;
    assign alu_b = (alumux2_sel == alumux2_rs2_out) ? rs2_out :
                   (alumux2_sel == alumux2_u_imm)   ? u_imm   :
                   (alumux2_sel == alumux2_b_imm)   ? b_imm   :
                   (alumux2_sel == alumux2_s_imm)   ? s_imm   :
                   (alumux2_sel == alumux2_j_imm)   ? j_imm   : i_imm;
    assign cmp_b = (cmpmux_sel == cmpmux_i_imm) ? i_imm : rs2_out;

    control_rom u_control_rom (
        .opcode(rv32i_opcode'(instr[6:0])), .funct3(instr[14:12]), .funct7(instr[31:25]),
        .load_regfile(load_regfile), .pcmux_sel(pcmux_sel), .alumux1_sel(alumux1_sel),
        .alumux2_sel(alumux2_sel), .cmpmux_sel(cmpmux_sel),
        .regfilemux_sel(regfilemux_sel), .aluop(aluop), .cmpop(cmpop)
    );

    regfile u_regfile (
        .clk(clk), .arst_n(arst_n), .load(load), .rs1(instr[19:15]), .rs2(instr[24:20]),
        .rd(instr[11:7]), .rd_data(rd_data), .rs1_out(rs1_out), .rs2_out(rs2_out)
    );

    imm_gen u_imm_gen (
        .instr(instr), .i_imm(i_imm), .s_imm(s_imm), .b_imm(b_imm),
        .u_imm(u_imm), .j_imm(j_imm)
    );

    alu u_alu (.aluop(aluop), .a(alu_a), .b(alu_b), .f(alu_out));

    cmp u_cmp (.cmpop(cmpop), .a(rs1_out), .b(cmp_b), .br_en(br_en));

    pc_unit #(.RESET_PC(RESET_PC)) u_pc_unit (
        .clk(clk), .arst_n(arst_n), .advance(instr_valid), .pcmux_sel(pcmux_sel),
        .br_en(br_en), .alu_out(alu_out), .pc(pc), .pc_plus4(pc_plus4)
    );

    writeback u_writeback (
        .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .load_regfile(load_regfile),
        .regfilemux_sel(regfilemux_sel), .rd(instr[11:7]), .alu_out(alu_out),
        .u_imm(u_imm), .pc_plus4(pc_plus4), .br_en(br_en), .load(load), .rd_data(rd_data),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule : rv32i_exec_top

`default_nettype wire

// ==== bench/rv32i_exec_props.sv ====
`default_nettype none

module rv32i_exec_props (
    input logic        clk,
    input logic        arst_n,
    input logic        instr_valid,
    input logic [31:0] pc,
    input logic        wb_valid,
    input logic [4:0]  wb_rd
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0; // read by the testbench top

    wb_needs_instr: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> $past(instr_valid))
        else begin
            $error("write-back report without an instruction in the cycle before");
            fail_count++;
        end

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> (wb_rd != 5'd0))
        else begin
            $error("write-back report names x0");
            fail_count++;
        end

    pc_holds_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !$past(instr_valid) |-> $stable(pc))
        else begin
            $error("pc moved after an idle cycle");
            fail_count++;
        end

    // sampled mid-cycle, after the first edge has cleared the flops
    wb_low_in_reset: assert property (@(negedge clk)
        !arst_n |-> !wb_valid)
        else begin
            $error("write-back report high during reset");
            fail_count++;
        end

endmodule : rv32i_exec_props

bind rv32i_exec_top rv32i_exec_props u_rv32i_exec_props (
    .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .pc(pc),
    .wb_valid(wb_valid), .wb_rd(wb_rd)
);

`default_nettype wire

// ==== bench/rv32i_exec_checker.sv ====
`default_nettype none

module rv32i_exec_checker #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        exp_strobe,
    input  string       exp_name,
    input  logic        exp_wb_valid,
    input  logic [4:0]  exp_wb_rd,
    input  logic [31:0] exp_wb_data,
    input  logic [31:0] exp_pc,
    input  logic [31:0] pc,
    input  logic        wb_valid,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output int          error_count,
    output int          check_count
);

    timeunit 1ns;
    timeprecision 1ps;

    logic        check_due = 1'b0;
    string       cur_name;
    logic        cur_wb_valid;
    logic [4:0]  cur_wb_rd;
    logic [31:0] cur_wb_data;
    logic [31:0] cur_pc;
    logic [31:0] last_pc = RESET_PC;
    string       last_name = "reset";
    int          errors = 0;
    int          checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_value(input string ctx, input string name, input string field,
            input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s%s: %s expected %h actual %h", ctx, name, field, expected, actual);
            errors++;
        end
    endtask

    // latch the entry for the instruction taken at this edge
    always @(posedge clk) begin
        check_due <= exp_strobe && arst_n;
        if (exp_strobe) begin
            cur_name     <= exp_name;
            cur_wb_valid <= exp_wb_valid;
            cur_wb_rd    <= exp_wb_rd;
            cur_wb_data  <= exp_wb_data;
            cur_pc       <= exp_pc;
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (check_due) begin
                checks++;
                compare_value("", cur_name, "wb_valid", 32'(cur_wb_valid), 32'(wb_valid));
                if (cur_wb_valid) begin
                    compare_value("", cur_name, "wb_rd", 32'(cur_wb_rd), 32'(wb_rd));
                    compare_value("", cur_name, "wb_data", cur_wb_data, wb_data);
                end
                compare_value("", cur_name, "pc", cur_pc, pc);
                last_pc   = cur_pc;
                last_name = cur_name;
            end else begin
                compare_value("idle after ", last_name, "pc", last_pc, pc); // must hold
                compare_value("idle after ", last_name, "wb_valid", 32'd0, 32'(wb_valid));
            end
        end
    end

endmodule : rv32i_exec_checker

`default_nettype wire

// ==== bench/rv32i_exec_tb.sv ====
`default_nettype none

module rv32i_exec_tb
    import rv32i_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam int RESET_CYCLES = 8;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic        exp_strobe;
    string       exp_name;
    logic        exp_wb_valid;
    logic [4:0]  exp_wb_rd;
    logic [31:0] exp_wb_data;
    logic [31:0] exp_pc;
    int          error_count;
    int          check_count;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    // stimulus table with one queue per column
    string       names[$];
    logic [31:0] words[$];
    logic        valids[$];
    logic [4:0]  rds[$];
    logic [31:0] datas[$];
    logic [31:0] next_pcs[$];

    always #2 clk = ~clk;

    rv32i_exec_top #(.RESET_PC(RESET_PC)) u_rv32i_exec_top (
        .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
        .pc(pc), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    rv32i_exec_checker #(.RESET_PC(RESET_PC)) u_checker (
        .clk(clk), .arst_n(arst_n), .exp_strobe(exp_strobe), .exp_name(exp_name),
        .exp_wb_valid(exp_wb_valid), .exp_wb_rd(exp_wb_rd), .exp_wb_data(exp_wb_data),
        .exp_pc(exp_pc), .pc(pc), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .error_count(error_count), .check_count(check_count)
    );

    function automatic logic [31:0] rtype(input logic [6:0] funct7, input int rs2, input int rs1,
            input logic [2:0] funct3, input int rd);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], op_reg};
    endfunction

    function automatic logic [31:0] itype(input int imm, input int rs1, input logic [2:0] funct3,
            input int rd, input logic [6:0] opcode);
        return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
    endfunction

    function automatic logic [31:0] utype(input int imm20, input int rd, input logic [6:0] opcode);
        return {imm20[19:0], rd[4:0], opcode};
    endfunction

    function automatic logic [31:0] btype(input int offset, input int rs2, input int rs1,
            input logic [2:0] funct3);
        return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3, offset[4:1], offset[11],
                op_br};
    endfunction

    function automatic logic [31:0] jtype(input int offset, input int rd);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], op_jal};
    endfunction

    function automatic logic [31:0] stype(input int imm, input int rs2, input int rs1,
            input logic [2:0] funct3);
        return {imm[11:5], rs2[4:0], rs1[4:0], funct3, imm[4:0], op_store};
    endfunction

    task automatic push_test(input string name, input logic [31:0] word, input int wbv,
            input int rd, input logic [31:0] data, input logic [31:0] next_pc);
        names.push_back(name);
        words.push_back(word);
        valids.push_back(wbv[0]);
        rds.push_back(rd[4:0]);
        datas.push_back(data);
        next_pcs.push_back(next_pc);
    endtask

    // later tests lean on x1=8000_0000 x2=-5 x3=12 x4=300c
    task automatic build_table();
        push_test("lui x1", utype('h80000, 1, op_lui), 1, 1, 32'h8000_0000, 32'h1004);
        push_test("addi x2", itype(-5, 0, add, 2, op_imm), 1, 2, 32'hffff_fffb, 32'h1008);
        push_test("addi x3", itype(12, 0, add, 3, op_imm), 1, 3, 32'h0000_000c, 32'h100c);
        push_test("auipc x4", utype('h2, 4, op_auipc), 1, 4, 32'h0000_300c, 32'h1010);
        push_test("add x5", rtype(7'h00, 3, 2, add, 5), 1, 5, 32'h0000_0007, 32'h1014);
        push_test("sub x6", rtype(7'h20, 2, 3, add, 6), 1, 6, 32'h0000_0011, 32'h1018);
        push_test("xor x7", rtype(7'h00, 3, 2, axor, 7), 1, 7, 32'hffff_fff7, 32'h101c);
        push_test("or x8", rtype(7'h00, 3, 2, aor, 8), 1, 8, 32'hffff_ffff, 32'h1020);
        push_test("and x9", rtype(7'h00, 3, 2, aand, 9), 1, 9, 32'h0000_0008, 32'h1024);
        push_test("xori x10", itype('h0f5, 3, axor, 10, op_imm), 1, 10, 32'h0000_00f9, 32'h1028);
        push_test("ori x11", itype(-16, 3, aor, 11, op_imm), 1, 11, 32'hffff_fffc, 32'h102c);
        push_test("andi x12", itype('h0ff, 2, aand, 12, op_imm), 1, 12, 32'h0000_00fb, 32'h1030);
        push_test("sll x13", rtype(7'h00, 3, 2, sll, 13), 1, 13, 32'hffff_b000, 32'h1034);
        push_test("srl x14", rtype(7'h00, 3, 2, sr, 14), 1, 14, 32'h000f_ffff, 32'h1038);
        push_test("sra x15", rtype(7'h20, 3, 1, sr, 15), 1, 15, 32'hfff8_0000, 32'h103c);
        push_test("slli x16", itype(4, 2, sll, 16, op_imm), 1, 16, 32'hffff_ffb0, 32'h1040);
        push_test("srli x17", itype(28, 2, sr, 17, op_imm), 1, 17, 32'h0000_000f, 32'h1044);
        push_test("srai x18", itype('h401, 2, sr, 18, op_imm), 1, 18, 32'hffff_fffd, 32'h1048);
        push_test("slt x19", rtype(7'h00, 3, 2, slt, 19), 1, 19, 32'h0000_0001, 32'h104c);
        push_test("sltu x20", rtype(7'h00, 3, 2, sltu, 20), 1, 20, 32'h0000_0000, 32'h1050);
        push_test("slti x21", itype(4, 2, slt, 21, op_imm), 1, 21, 32'h0000_0001, 32'h1054);
        push_test("sltiu x22", itype(-1, 3, sltu, 22, op_imm), 1, 22, 32'h0000_0001, 32'h1058);
        push_test("sltiu x23", itype(5, 2, sltu, 23, op_imm), 1, 23, 32'h0000_0000, 32'h105c);
        push_test("beq taken", btype(8, 3, 3, beq), 0, 0, 32'h0, 32'h1064);
        push_test("beq not taken", btype(16, 3, 2, beq), 0, 0, 32'h0, 32'h1068);
        push_test("bne taken", btype(-8, 3, 2, bne), 0, 0, 32'h0, 32'h1060);
        push_test("bne not taken", btype(12, 3, 3, bne), 0, 0, 32'h0, 32'h1064);
        push_test("blt taken", btype(32, 3, 2, blt), 0, 0, 32'h0, 32'h1084);
        push_test("blt not taken", btype(32, 2, 3, blt), 0, 0, 32'h0, 32'h1088);
        push_test("bge taken", btype(-16, 2, 3, bge), 0, 0, 32'h0, 32'h1078);
        push_test("bge not taken", btype(8, 3, 2, bge), 0, 0, 32'h0, 32'h107c);
        push_test("bltu taken", btype(256, 2, 3, bltu), 0, 0, 32'h0, 32'h117c);
        push_test("bltu not taken", btype(4, 3, 2, bltu), 0, 0, 32'h0, 32'h1180);
        push_test("bgeu taken", btype(-128, 3, 2, bgeu), 0, 0, 32'h0, 32'h1100);
        push_test("bgeu not taken", btype(8, 2, 3, bgeu), 0, 0, 32'h0, 32'h1104);
        push_test("jal x24", jtype(512, 24), 1, 24, 32'h0000_1108, 32'h1304);
        push_test("jalr x25", itype(5, 4, 3'b000, 25, op_jalr), 1, 25, 32'h0000_1308, 32'h3010);
        push_test("jal back x26", jtype(-16, 26), 1, 26, 32'h0000_3014, 32'h3000);
        push_test("addi x0", itype(1, 3, add, 0, op_imm), 0, 0, 32'h0, 32'h3004);
        push_test("add x27 from x0", rtype(7'h00, 3, 0, add, 27), 1, 27, 32'h0000_000c, 32'h3008);
        push_test("store nop", stype(4, 3, 2, 3'b010), 0, 0, 32'h0, 32'h300c);
        push_test("addi x29 x4", itype(0, 4, add, 29, op_imm), 1, 29, 32'h0000_300c, 32'h3010);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles, instructions checked %0d of %0d",
                     cycle_count, check_count, names.size());
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int n_idle;
        int assert_fails;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = 32'h0;
        exp_strobe   = 1'b0;
        exp_name     = "";
        exp_wb_valid = 1'b0;
        exp_wb_rd    = 5'd0;
        exp_wb_data  = 32'h0;
        exp_pc       = 32'h0;
        void'($urandom(32'h990b));
        build_table();
        cycle_limit = RESET_CYCLES + 4 * names.size() + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < names.size(); i++) begin
            n_idle = $urandom % 3; // 0 to 2 idle cycles
            repeat (n_idle) begin
                @(posedge clk);
                instr_valid <= 1'b0;
                exp_strobe  <= 1'b0;
            end
            @(posedge clk);
            instr        <= words[i];
            instr_valid  <= 1'b1;
            exp_strobe   <= 1'b1;
            exp_name     <= names[i];
            exp_wb_valid <= valids[i];
            exp_wb_rd    <= rds[i];
            exp_wb_data  <= datas[i];
            exp_pc       <= next_pcs[i];
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        exp_strobe  <= 1'b0;

        while (check_count < names.size()) @(posedge clk);
        repeat (2) @(posedge clk); // a few idle checks at the tail

        assert_fails = u_rv32i_exec_top.u_rv32i_exec_props.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : rv32i_exec_tb

`default_nettype wire

// ==== filelist.f ====
hdl/rv32i_pkg.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/cmp.sv
hdl/pc_unit.sv
hdl/writeback.sv
hdl/rv32i_exec_top.sv
bench/rv32i_exec_props.sv
bench/rv32i_exec_checker.sv
bench/rv32i_exec_tb.sv
